// File: build.f
rtl/tpu_pkg.sv
rtl/mac_cell.sv
rtl/systolic_array.sv
rtl/input_skew.sv
rtl/output_deskew.sv
rtl/tpu_ctrl.sv
rtl/tpu_top.sv
sim/tpu_asserts.sv
sim/tpu_tb.sv

// File: rtl/input_skew.sv
// Input skew for the array's left edge
// Lane c of each A row is held back c cycles to form the wavefront

`timescale 1ns/1ns

module input_skew
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input  logic          clk,
	input  logic          rst,
	input  word_t         row_i,
	output elem_t [N-1:0] act_o
);

	for (genvar c = 0; c < N; c++) begin : g_lane
		elem_t lane;

		assign lane = row_i[(N-1-c)*DATA_W +: DATA_W];  // Lane 0 in top byte

		if (c == 0) begin : g_pass
			assign act_o[c] = lane;
		end else begin : g_dly
			elem_t sr [c];

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					for (int i = 0; i < c; i++) begin
						sr[i] <= '0;
					end
				end else begin
					sr[0] <= lane;
					for (int i = 1; i < c; i++) begin
						sr[i] <= sr[i-1];
					end
				end
			end

			assign act_o[c] = sr[c-1];
		end
	end

endmodule

// File: rtl/mac_cell.sv
// Multiply-accumulate cell of the weight-stationary array
// Holds one weight, forwards activations right and sums downward

`timescale 1ns/1ns

module mac_cell
	import tpu_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  weight_clr_i,
	input  logic  weight_en_i,
	input  elem_t weight_i,
	input  elem_t act_i,
	input  elem_t psum_i,
	output elem_t act_o,
	output elem_t psum_o
);

	elem_t weight;

	// Clear wins over a weight load
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weight <= '0;
		end else if (weight_clr_i) begin
			weight <= '0;
		end else if (weight_en_i) begin
			weight <= weight_i;
		end
	end

	// Product truncated to the element width before the add
	always_ff @(posedge clk) begin
		act_o  <= act_i;
		psum_o <= psum_i + elem_t'(act_i * weight);
	end

endmodule

// File: rtl/output_deskew.sv
// Output deskew for the array's bottom edge
// Column j waits N-1-j cycles so one result row lines up,
// then columns at or beyond n are zeroed and packed into a word

`timescale 1ns/1ns

module output_deskew
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input  logic          clk,
	input  logic          rst,
	input  dim_t          n_i,
	input  elem_t [N-1:0] psum_i,
	output word_t         row_o
);

	for (genvar j = 0; j < N; j++) begin : g_col
		localparam int DLY = N - 1 - j;

		elem_t col;

		if (DLY == 0) begin : g_pass
			assign col = psum_i[j];  // Last column finishes last
		end else begin : g_dly
			elem_t sr [DLY];

			always_ff @(posedge clk or posedge rst) begin
				if (rst) begin
					for (int i = 0; i < DLY; i++) begin
						sr[i] <= '0;
					end
				end else begin
					sr[0] <= psum_i[j];
					for (int i = 1; i < DLY; i++) begin
						sr[i] <= sr[i-1];
					end
				end
			end

			assign col = sr[DLY-1];
		end

		// Columns past n hold junk from unused B lanes
		assign row_o[(N-1-j)*DATA_W +: DATA_W] = (dim_t'(j) < n_i) ? col : '0;
	end

endmodule

// File: rtl/systolic_array.sv
// N x N grid of MAC cells
// Weights load one row at a time; activations enter left, sums leave at the bottom

`timescale 1ns/1ns

module systolic_array
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              weight_clr_i,
	input  logic [N-1:0]      weight_row_en_i,
	input  word_t             weight_row_i,
	input  elem_t [N-1:0]     act_left_i,
	output elem_t [N-1:0]     psum_bottom_o
);

	// act_h[r][c] enters cell (r,c) from the left
	elem_t act_h [N][N];
	// psum_v[r][c] enters cell (r,c) from above and row N is the bottom edge
	elem_t psum_v [N+1][N];

	for (genvar r = 0; r < N; r++) begin : g_left
		assign act_h[r][0] = act_left_i[r];
	end

	for (genvar c = 0; c < N; c++) begin : g_edge
		assign psum_v[0][c]     = '0;  // Nothing above the top row
		assign psum_bottom_o[c] = psum_v[N][c];
	end

	for (genvar r = 0; r < N; r++) begin : g_row
		for (genvar c = 0; c < N; c++) begin : g_col
			if (c < N - 1) begin : g_inner
				mac_cell i_mac_cell (
					.clk          (clk),
					.rst          (rst),
					.weight_clr_i (weight_clr_i),
					.weight_en_i  (weight_row_en_i[r]),
					.weight_i     (weight_row_i[(N-1-c)*DATA_W +: DATA_W]),
					.act_i        (act_h[r][c]),
					.psum_i       (psum_v[r][c]),
					.act_o        (act_h[r][c+1]),
					.psum_o       (psum_v[r+1][c])
				);
			end else begin : g_right
				// Activation leaves the array at the right edge
				mac_cell i_mac_cell (
					.clk          (clk),
					.rst          (rst),
					.weight_clr_i (weight_clr_i),
					.weight_en_i  (weight_row_en_i[r]),
					.weight_i     (weight_row_i[(N-1-c)*DATA_W +: DATA_W]),
					.act_i        (act_h[r][c]),
					.psum_i       (psum_v[r][c]),
					.act_o        (),
					.psum_o       (psum_v[r+1][c])
				);
			end
		end
	end

endmodule

// File: rtl/tpu_ctrl.sv
// Controller FSM for weight load, A streaming, drain and done
// Drives memory indices, weight row enables and the write strobe pipeline

`timescale 1ns/1ns

module tpu_ctrl
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         start_i,
	input  dim_t         m_i,
	input  dim_t         k_i,
	output idx_t         index_a_o,
	output idx_t         index_b_o,
	output idx_t         index_o_o,
	output logic         weight_clr_o,
	output logic [N-1:0] weight_row_en_o,
	output logic         wr_en_o,
	output logic         done_o
);

	// Skew, array and deskew together take 2N cycles after the read
	localparam int LAT = 2 * N;
	localparam logic [N-1:0] ROW0 = 1;

	ctrl_state_t state;

	logic [LAT-1:0] vld_sr;  // One bit per A row in flight
	logic start_ok;
	logic load_last;
	logic strm_last;
	logic wr_last;

	// DONE behaves as idle with done still raised
	assign start_ok  = start_i && (state == IDLE || state == DONE);
	assign load_last = index_b_o == idx_t'(k_i) - idx_t'(1);
	assign strm_last = index_a_o == idx_t'(m_i) - idx_t'(1);
	assign wr_last   = wr_en_o && (index_o_o + idx_t'(1) == idx_t'(m_i));

	assign wr_en_o = vld_sr[LAT-1];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state        <= IDLE;
			index_a_o    <= '0;
			index_b_o    <= '0;
			weight_clr_o <= 1'b0;
			done_o       <= 1'b0;
		end else begin
			weight_clr_o <= start_ok;  // Wipe old weights before row 0 lands
			case (state)
				IDLE, DONE: begin
					if (start_ok) begin
						state     <= LOAD;
						index_b_o <= '0;
						done_o    <= 1'b0;
					end
				end
				LOAD: begin
					if (load_last) begin
						state     <= STREAM;
						index_a_o <= '0;
					end else begin
						index_b_o <= index_b_o + idx_t'(1);
					end
				end
				STREAM: begin
					// One A row per cycle with no gaps
					if (strm_last) begin
						state <= DRAIN;
					end else begin
						index_a_o <= index_a_o + idx_t'(1);
					end
				end
				DRAIN: begin
					if (wr_last) begin
						state  <= DONE;
						done_o <= 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// B row r is on the data bus one cycle after index_b_o was r
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			weight_row_en_o <= '0;
		end else if (state == LOAD) begin
			weight_row_en_o <= ROW0 << index_b_o;
		end else begin
			weight_row_en_o <= '0;
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[LAT-2:0], state == STREAM};
		end
	end

	// Write address restarts with each run
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			index_o_o <= '0;
		end else if (start_ok) begin
			index_o_o <= '0;
		end else if (wr_en_o) begin
			index_o_o <= index_o_o + idx_t'(1);
		end
	end

endmodule

// File: rtl/tpu_pkg.sv
// Shared constants and types for the systolic matrix multiplier
// Array size, element and word widths, index types, controller states

package tpu_pkg;

	localparam int ARRAY_N = 5;                 // Array is ARRAY_N x ARRAY_N cells
	localparam int DATA_W  = 8;                 // Arithmetic wraps at the element width
	localparam int WORD_W  = ARRAY_N * DATA_W;  // One packed matrix row

	typedef logic [DATA_W-1:0] elem_t;

	// Lane 0 sits in the top byte
	typedef logic [WORD_W-1:0] word_t;

	typedef logic [3:0] dim_t;  // m, k or n
	typedef logic [7:0] idx_t;  // Memory row index

	// DONE keeps done raised and waits for the next start
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		STREAM,
		DRAIN,
		DONE
	} ctrl_state_t;

endpackage

// File: rtl/tpu_top.sv
// Top level of the systolic matrix multiplier
// Controller, input skew, MAC array and output deskew

`timescale 1ns/1ns

module tpu_top
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  start_i,
	input  dim_t  m_i,
	input  dim_t  k_i,
	input  dim_t  n_i,
	input  word_t data_in_a_i,
	input  word_t data_in_b_i,
	output idx_t  index_a_o,
	output idx_t  index_b_o,
	output idx_t  index_o_o,
	output logic  wr_en_o,
	output word_t data_out_o,
	output logic  done_o
);

	logic          weight_clr;
	logic [N-1:0]  weight_row_en;
	elem_t [N-1:0] act_left;     // Skewed lanes into the left edge
	elem_t [N-1:0] psum_bottom;

	tpu_ctrl #(.N(N)) i_tpu_ctrl (
		.clk             (clk),
		.rst             (rst),
		.start_i         (start_i),
		.m_i             (m_i),
		.k_i             (k_i),
		.index_a_o       (index_a_o),
		.index_b_o       (index_b_o),
		.index_o_o       (index_o_o),
		.weight_clr_o    (weight_clr),
		.weight_row_en_o (weight_row_en),
		.wr_en_o         (wr_en_o),
		.done_o          (done_o)
	);

	input_skew #(.N(N)) i_input_skew (
		.clk   (clk),
		.rst   (rst),
		.row_i (data_in_a_i),
		.act_o (act_left)
	);

	// B rows come straight from memory as weights
	systolic_array #(.N(N)) i_systolic_array (
		.clk             (clk),
		.rst             (rst),
		.weight_clr_i    (weight_clr),
		.weight_row_en_i (weight_row_en),
		.weight_row_i    (data_in_b_i),
		.act_left_i      (act_left),
		.psum_bottom_o   (psum_bottom)
	);

	output_deskew #(.N(N)) i_output_deskew (
		.clk    (clk),
		.rst    (rst),
		.n_i    (n_i),
		.psum_i (psum_bottom),
		.row_o  (data_out_o)
	);

endmodule

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tpu_tb -f build.f -o tpu_sim
if [ $? -ne 0 ]; then
	echo "compile step returned an error"
	exit 1
fi

./obj_dir/tpu_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if grep -qx "all tests passed" sim.log; then
	exit 0
fi
exit 1

// File: sim/tpu_asserts.sv
// Concurrent checks on the controller outputs
// Bound into tpu_ctrl by the testbench

`timescale 1ns/1ns

module tpu_asserts
	import tpu_pkg::*;
#(
	parameter int N = ARRAY_N
) (
	input logic         clk,
	input logic         rst,
	input dim_t         m_i,
	input dim_t         k_i,
	input idx_t         wr_index_i,
	input logic         wr_en_i,
	input logic         done_i,
	input logic [N-1:0] row_en_i
);

	// Writes are over once done is raised
	a_no_wr_when_done: assert property (@(posedge clk) disable iff (rst)
		!(wr_en_i && done_i))
		else $error("wr_en_o high while done_o is high");

	a_wr_index_range: assert property (@(posedge clk) disable iff (rst)
		wr_en_i |-> (wr_index_i < idx_t'(m_i)))
		else $error("write index %0d not below m %0d", wr_index_i, m_i);

	// Only rows below k ever take a weight
	a_row_en_onehot: assert property (@(posedge clk) disable iff (rst)
		$onehot0(row_en_i) && ((row_en_i >> k_i) == '0))
		else $error("weight_row_en_o not one-hot below k %0d: %b", k_i, row_en_i);

endmodule

// File: sim/tpu_tb.sv
// Testbench for the systolic matrix multiplier
// Memory models, write monitor, reference model, directed tests and watchdog

`timescale 1ns/1ns

module tpu_tb
	import tpu_pkg::*;
();

	localparam int LAT  = 2 * ARRAY_N;  // Index to write latency
	localparam int ROWS = 16;           // Rows refilled per test

	function automatic int run_budget(input int k, input int m);
		return k + m + LAT + 20;
	endfunction

	localparam int TIMEOUT_CYC = 2 * (run_budget(5, 5) + run_budget(5, 5) + run_budget(3, 4)
		+ run_budget(5, 15) + run_budget(5, 6) + run_budget(3, 5));

	logic  clk = 1'b0;
	logic  rst = 1'b1;
	logic  start_i = 1'b0;
	dim_t  m_i = '0;
	dim_t  k_i = '0;
	dim_t  n_i = '0;
	word_t data_a = '0;
	word_t data_b = '0;
	idx_t  index_a;
	idx_t  index_b;
	idx_t  index_o;
	logic  wr_en;
	logic  done;
	word_t data_out;

	word_t       mem_a [256];
	word_t       mem_b [256];
	logic [31:0] lfsr = 32'hab1e;
	int          cyc = 0;
	int          errors = 0;
	int          bad_tests = 0;
	int          done_rise_cyc = -1;
	logic        done_prev = 1'b0;
	idx_t        a_hist [LAT+1];  // Entry s holds index_a from s cycles back

	// One entry per observed write
	int    wr_cyc_q [$];
	idx_t  wr_idx_q [$];
	idx_t  wr_a_q [$];
	word_t wr_data_q [$];

	always #5 clk = ~clk;

	tpu_top i_tpu_top (
		.clk         (clk),
		.rst         (rst),
		.start_i     (start_i),
		.m_i         (m_i),
		.k_i         (k_i),
		.n_i         (n_i),
		.data_in_a_i (data_a),
		.data_in_b_i (data_b),
		.index_a_o   (index_a),
		.index_b_o   (index_b),
		.index_o_o   (index_o),
		.wr_en_o     (wr_en),
		.data_out_o  (data_out),
		.done_o      (done)
	);

	bind tpu_ctrl tpu_asserts #(.N(N)) i_tpu_asserts (
		.clk        (clk),
		.rst        (rst),
		.m_i        (m_i),
		.k_i        (k_i),
		.wr_index_i (index_o_o),
		.wr_en_i    (wr_en_o),
		.done_i     (done_o),
		.row_en_i   (weight_row_en_o)
	);

	// Synchronous read ports
	always @(posedge clk) begin
		data_a <= mem_a[index_a];
		data_b <= mem_b[index_b];
	end

	always @(posedge clk) begin
		cyc = cyc + 1;
		if (cyc > TIMEOUT_CYC) begin
			$display("timeout: run still going after %0d cycles", cyc);
			$display("tests failed");
			$finish;
		end
	end

	// Result memory write port is sampled mid-cycle
	always @(negedge clk) begin
		for (int s = LAT; s > 0; s--) begin
			a_hist[s] = a_hist[s-1];
		end
		a_hist[0] = index_a;
		if (wr_en) begin
			wr_cyc_q.push_back(cyc);
			wr_idx_q.push_back(index_o);
			wr_a_q.push_back(a_hist[LAT]);
			wr_data_q.push_back(data_out);
		end
		if (done && !done_prev) begin
			done_rise_cyc = cyc;
		end
		done_prev = done;
	end

	// Galois LFSR with polynomial x^32 + x^22 + x^2 + x + 1
	function automatic word_t rand_word();
		word_t w;
		w = '0;
		for (int b = 0; b < WORD_W; b++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			w = {w[WORD_W-2:0], lfsr[0]};
		end
		return w;
	endfunction

	function automatic elem_t lane(input word_t w, input int c);
		return w[(ARRAY_N-1-c)*DATA_W +: DATA_W];  // Lane 0 is the top byte
	endfunction

	// C[i][j] = sum over c < k of A[i][c] * B[c][j], mod 256
	function automatic word_t ref_row(input int i, input int k, input int n);
		word_t row;
		elem_t acc;
		row = '0;
		for (int j = 0; j < n; j++) begin
			acc = '0;
			for (int c = 0; c < k; c++) begin
				acc = acc + lane(mem_a[i], c) * lane(mem_b[c], j);
			end
			row[(ARRAY_N-1-j)*DATA_W +: DATA_W] = acc;
		end
		return row;
	endfunction

	task automatic report_error(input string msg);
		$display("ERROR t=%0t %s", $time, msg);
		errors++;
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_index(input string name, input idx_t got, input idx_t exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %0d expected %0d", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		if (errors == err_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - err_before);
			bad_tests++;
		end
	endtask

	task automatic fill_random();
		for (int r = 0; r < ROWS; r++) begin
			mem_a[r] = rand_word();
			mem_b[r] = rand_word();
		end
	endtask

	// One start-to-done run, then all writes of the run are checked
	task automatic run_matmul(input int m, input int k, input int n, input bit poke,
		output int base);
		int nw;
		base = wr_cyc_q.size();
		m_i <= dim_t'(m);
		k_i <= dim_t'(k);
		n_i <= dim_t'(n);
		start_i <= 1'b1;
		@(posedge clk);
		start_i <= 1'b0;
		@(posedge clk);
		check_flag("done_o after start", done, 1'b0);
		if (poke) begin
			// Earlier run left index_a at its last row
			while (index_a != idx_t'(0)) @(posedge clk);
			while (index_a != idx_t'(2)) @(posedge clk);
			start_i <= 1'b1;  // Ignored in mid-stream
			@(posedge clk);
			start_i <= 1'b0;
		end
		while (done !== 1'b1) @(posedge clk);
		nw = wr_cyc_q.size() - base;
		if (nw != m) begin
			report_error($sformatf("expected %0d writes, saw %0d", m, nw));
		end
		for (int w = 0; w < nw && w < m; w++) begin
			check_index("index_o_o", wr_idx_q[base+w], idx_t'(w));
			check_index("index_a_o 2N cycles before write", wr_a_q[base+w], idx_t'(w));
			check_word("data_out_o", wr_data_q[base+w], ref_row(w, k, n));
			if (w > 0 && wr_cyc_q[base+w] != wr_cyc_q[base+w-1] + 1) begin
				report_error($sformatf("write %0d not in the cycle after write %0d", w, w - 1));
			end
		end
		if (nw > 0 && done_rise_cyc != wr_cyc_q[base+nw-1] + 1) begin
			report_error("done_o did not rise in the cycle after the last write");
		end
		repeat (4) begin
			@(posedge clk);
			check_flag("done_o", done, 1'b1);
		end
	endtask

	task automatic test_identity();
		int e0;
		int base;
		e0 = errors;
		fill_random();
		for (int r = 0; r < ARRAY_N; r++) begin
			mem_b[r] = word_t'(1) << ((ARRAY_N - 1 - r) * DATA_W);
		end
		run_matmul(5, 5, 5, 1'b0, base);
		for (int i = 0; i < 5 && base + i < wr_data_q.size(); i++) begin
			check_word("data_out_o vs A row", wr_data_q[base+i], mem_a[i]);
		end
		report_test("identity", e0);
	endtask

	task automatic test_random_full();
		int e0;
		int base;
		e0 = errors;
		fill_random();
		run_matmul(5, 5, 5, 1'b0, base);
		report_test("random full size", e0);
	endtask

	// Random bytes fill the unused lanes and rows
	task automatic test_partial();
		int e0;
		int base;
		e0 = errors;
		fill_random();
		run_matmul(4, 3, 2, 1'b0, base);
		report_test("partial dimensions", e0);
	endtask

	task automatic test_streaming();
		int e0;
		int base;
		e0 = errors;
		fill_random();
		run_matmul(15, 5, 5, 1'b0, base);
		check_index("index_o_o after run", index_o, idx_t'(15));
		report_test("streaming", e0);
	endtask

	// Second run has k=3, so rows 3 and 4 must hold cleared weights
	task automatic test_done_restart();
		int e0;
		int base;
		e0 = errors;
		fill_random();
		run_matmul(6, 5, 4, 1'b1, base);
		fill_random();
		run_matmul(5, 3, 5, 1'b0, base);
		report_test("done and restart", e0);
	endtask

	initial begin
		for (int a = 0; a < 256; a++) begin
			mem_a[a] = {ARRAY_N{idx_t'(a)}};
			mem_b[a] = ~{ARRAY_N{idx_t'(a)}};
		end
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_flag("done_o after reset", done, 1'b0);
		check_flag("wr_en_o after reset", wr_en, 1'b0);
		test_identity();
		test_random_full();
		test_partial();
		test_streaming();
		test_done_restart();
		$display("tests run 5, with errors %0d, errors %0d", bad_tests, errors);
		if (errors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
